/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int addr_width     = 32;
	localparam int data_width     = 32;
	localparam int bus_width      = 64;
	localparam int strb_width     = 8;
	localparam int reg_addr_width = 5;

	typedef logic [addr_width-1:0]     addr_t;
	typedef logic [data_width-1:0]     word_t;
	typedef logic [bus_width-1:0]      bus_data_t;
	typedef logic [strb_width-1:0]     strb_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw
	} lsu_op_t;

	// bus stage states
	typedef enum logic [2:0] {
		seq_idle, seq_request, seq_wait_resp, seq_second_request, seq_second_wait, seq_done
	} seq_state_t;

	// --------------------------------------------------
	// stage payloads
	// --------------------------------------------------
	typedef struct packed {
		lsu_op_t   op;
		addr_t     addr;
		word_t     store_data;
		reg_addr_t rd;
	} lsu_request_t;

	typedef struct packed {
		lsu_op_t   op;
		reg_addr_t rd;
		logic [1:0] addr_lo;
		addr_t     first_addr;
		addr_t     second_addr;
		strb_t     first_strb;
		strb_t     second_strb;
		bus_data_t bus_store_data;
		logic      two_beats;
	} access_plan_t;

	typedef struct packed {
		addr_t     addr;
		logic      write;
		strb_t     strb;
		bus_data_t wdata;
	} bus_request_t;

	typedef struct packed {
		bus_data_t rdata;
	} bus_response_t;

	typedef struct packed {
		lsu_op_t   op;
		reg_addr_t rd;
		logic [1:0] addr_lo;
		strb_t     first_strb;
		strb_t     second_strb;
		bus_data_t first_rdata;
		bus_data_t second_rdata;
	} beat_pair_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     data;
		logic      reg_write;
	} lsu_result_t;

endpackage

`default_nettype wire

/* logic/access_planner.sv */
`default_nettype none

module access_planner
	import lsu_pkg::*;
(
	input  wire logic   clock,
	input  wire logic   reset,
	input  wire logic   req_valid,
	input  lsu_request_t request,
	input  wire logic   plan_ready,
	output logic        req_ready,
	output logic        plan_valid,
	output access_plan_t plan
);

	logic [3:0]             byte_mask;
	logic [7:0]             word_mask;
	logic [2*bus_width-1:0] store_rot;
	addr_t                  first_addr;
	access_plan_t           next_plan;
	logic                   accept;

	// single entry, refilled in the cycle it drains
	assign req_ready = !plan_valid || plan_ready;
	assign accept    = req_valid && req_ready;

	// --------------------------------------------------
	// beat plan
	// --------------------------------------------------
	always_comb begin
		case (request.op)
			op_lw, op_sw:         byte_mask = 4'b1111;
			op_lh, op_lhu, op_sh: byte_mask = 4'b0011;
			default:              byte_mask = 4'b0001;
		endcase
	end

	// low nibble hits the first word, high nibble spills into the next
	assign word_mask  = {4'b0000, byte_mask} << request.addr[1:0];
	assign first_addr = {request.addr[addr_width-1:2], 2'b00};

	// rotate through 64 bits so upper bytes wrap into low lanes
	assign store_rot = {2{{(bus_width-data_width){1'b0}}, request.store_data}}
		<< {request.addr[2:0], 3'b000};

	always_comb begin
		next_plan.op          = request.op;
		next_plan.rd          = request.rd;
		next_plan.addr_lo     = request.addr[1:0];
		next_plan.first_addr  = first_addr;
		next_plan.second_addr = first_addr + addr_t'(4);
		next_plan.two_beats   = |word_mask[7:4];
		next_plan.bus_store_data = store_rot[2*bus_width-1:bus_width];
		// lane half follows bit 2 of each beat address
		if (request.addr[2]) begin
			next_plan.first_strb  = {word_mask[3:0], 4'b0000};
			next_plan.second_strb = {4'b0000, word_mask[7:4]};
		end else begin
			next_plan.first_strb  = {4'b0000, word_mask[3:0]};
			next_plan.second_strb = {word_mask[7:4], 4'b0000};
		end
	end

	// --------------------------------------------------
	// stage register
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			plan_valid <= 1'b0;
		end else if (accept) begin
			plan_valid <= 1'b1;
		end else if (plan_ready) begin
			plan_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			plan <= next_plan;
		end
	end

endmodule

`default_nettype wire

/* logic/bus_sequencer.sv */
`default_nettype none

module bus_sequencer
	import lsu_pkg::*;
(
	input  wire logic    clock,
	input  wire logic    reset,
	input  wire logic    plan_valid,
	input  access_plan_t plan,
	input  wire logic    mem_req_ready,
	input  wire logic    mem_resp_valid,
	input  bus_response_t mem_resp,
	output logic         plan_ready,
	output logic         mem_req_valid,
	output bus_request_t mem_req,
	output logic         mem_resp_ready,
	output logic         beats_valid,
	output beat_pair_t   beats
);

	seq_state_t   state;
	access_plan_t cur;
	bus_data_t    first_rdata;
	bus_data_t    second_rdata;
	logic         take_plan;
	logic         second_beat;

	// a new access starts only once the previous one is handed off
	assign plan_ready  = (state == seq_idle) || (state == seq_done);
	assign take_plan   = plan_valid && plan_ready;
	assign second_beat = (state == seq_second_request) || (state == seq_second_wait);

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= seq_idle;
		end else begin
			case (state)
				seq_idle, seq_done: begin
					if (take_plan) begin
						state <= seq_request;
					end else begin
						state <= seq_idle;
					end
				end
				seq_request: begin
					if (mem_req_ready) begin
						state <= seq_wait_resp;
					end
				end
				seq_wait_resp: begin
					if (mem_resp_valid) begin
						state <= cur.two_beats ? seq_second_request : seq_done;
					end
				end
				seq_second_request: begin
					if (mem_req_ready) begin
						state <= seq_second_wait;
					end
				end
				seq_second_wait: begin
					if (mem_resp_valid) begin
						state <= seq_done;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	// held access and returned beats
	always_ff @(posedge clock) begin
		if (take_plan) begin
			cur <= plan;
		end
		if (state == seq_wait_resp && mem_resp_valid) begin
			first_rdata <= mem_resp.rdata;
		end
		if (state == seq_second_wait && mem_resp_valid) begin
			second_rdata <= mem_resp.rdata;
		end
	end

	// --------------------------------------------------
	// bus side
	// --------------------------------------------------
	assign mem_req_valid  = (state == seq_request) || (state == seq_second_request);
	assign mem_resp_ready = (state == seq_wait_resp) || (state == seq_second_wait);

	// stores run the same beats, their response data is dropped later
	always_comb begin
		mem_req.addr  = second_beat ? cur.second_addr : cur.first_addr;
		mem_req.write = cur.op inside {op_sb, op_sh, op_sw};
		mem_req.strb  = second_beat ? cur.second_strb : cur.first_strb;
		mem_req.wdata = cur.bus_store_data;
	end

	// --------------------------------------------------
	// handoff to writeback
	// --------------------------------------------------
	assign beats_valid = (state == seq_done);

	always_comb begin
		beats.op           = cur.op;
		beats.rd           = cur.rd;
		beats.addr_lo      = cur.addr_lo;
		beats.first_strb   = cur.first_strb;
		// zero for single beats, so the aligner ignores the second word
		beats.second_strb  = cur.second_strb;
		beats.first_rdata  = first_rdata;
		beats.second_rdata = second_rdata;
	end

endmodule

`default_nettype wire

/* logic/load_aligner.sv */
`default_nettype none

module load_aligner
	import lsu_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire logic  beats_valid,
	input  beat_pair_t beats,
	output logic       result_valid,
	output lsu_result_t result
);

	localparam int word_bytes = data_width / 8;

	word_t                   gathered;
	logic [2*data_width-1:0] rotated;
	word_t                   aligned;
	word_t                   load_data;
	logic                    is_load;

	// byte k holds the accessed byte whose address is k mod 4
	always_comb begin
		for (int k = 0; k < word_bytes; k++) begin
			gathered[8*k +: 8] =
				({8{beats.first_strb[k]}} & beats.first_rdata[8*k +: 8])
				| ({8{beats.first_strb[k+word_bytes]}} & beats.first_rdata[8*k+data_width +: 8])
				| ({8{beats.second_strb[k]}} & beats.second_rdata[8*k +: 8])
				| ({8{beats.second_strb[k+word_bytes]}} & beats.second_rdata[8*k+data_width +: 8]);
		end
	end

	// bring the first byte of the access down to bits 7:0
	assign rotated = {gathered, gathered} >> {beats.addr_lo, 3'b000};
	assign aligned = rotated[data_width-1:0];

	assign is_load = beats.op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};

	always_comb begin
		case (beats.op)
			op_lb:   load_data = {{24{aligned[7]}}, aligned[7:0]};
			op_lbu:  load_data = {24'b0, aligned[7:0]};
			op_lh:   load_data = {{16{aligned[15]}}, aligned[15:0]};
			op_lhu:  load_data = {16'b0, aligned[15:0]};
			op_lw:   load_data = aligned;
			default: load_data = '0;
		endcase
	end

	// --------------------------------------------------
	// result register
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= beats_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (beats_valid) begin
			result.rd        <= beats.rd;
			result.data      <= load_data;
			result.reg_write <= is_load;
		end
	end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`default_nettype none

module lsu_top
	import lsu_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     req_valid,
	input  lsu_request_t  request,
	input  wire logic     mem_req_ready,
	input  wire logic     mem_resp_valid,
	input  bus_response_t mem_resp,
	output logic          req_ready,
	output logic          mem_req_valid,
	output bus_request_t  mem_req,
	output logic          mem_resp_ready,
	output logic          result_valid,
	output lsu_result_t   result
);

	// planner to sequencer
	logic         plan_valid;
	logic         plan_ready;
	access_plan_t plan;

	// sequencer to aligner, no back-pressure
	logic         beats_valid;
	beat_pair_t   beats;

	access_planner access_planner_inst (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.request    (request),
		.plan_ready (plan_ready),
		.req_ready  (req_ready),
		.plan_valid (plan_valid),
		.plan       (plan)
	);

	bus_sequencer bus_sequencer_inst (
		.clock          (clock),
		.reset          (reset),
		.plan_valid     (plan_valid),
		.plan           (plan),
		.mem_req_ready  (mem_req_ready),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp       (mem_resp),
		.plan_ready     (plan_ready),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_resp_ready (mem_resp_ready),
		.beats_valid    (beats_valid),
		.beats          (beats)
	);

	load_aligner load_aligner_inst (
		.clock        (clock),
		.reset        (reset),
		.beats_valid  (beats_valid),
		.beats        (beats),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// released just after the third rising edge
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

/* bench/mem_responder.sv */
`default_nettype none

module mem_responder
	import lsu_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     mem_req_valid,
	input  bus_request_t  mem_req,
	input  wire logic     mem_resp_ready,
	output logic          mem_req_ready = 1'b0,
	output logic          mem_resp_valid = 1'b0,
	output bus_response_t mem_resp = '0
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0]  mem [512];
	logic [15:0] lfsr = 16'd37915;
	logic        busy;
	int          ready_wait;
	int          resp_wait;
	int          base;

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// same fill as the bench model
	initial begin
		for (int i = 0; i < 512; i++) begin
			mem[i] = 8'(i * 13) ^ 8'(i >> 8);
		end
	end

	// --------------------------------------------------
	// one transaction at a time
	// --------------------------------------------------
	assign base = {23'b0, mem_req.addr[8:3], 3'b000};

	always @(posedge clock) begin
		if (reset) begin
			mem_req_ready  <= 1'b0;
			mem_resp_valid <= 1'b0;
			busy           <= 1'b0;
			ready_wait     <= 0;
			resp_wait      <= 0;
		end else begin
			mem_req_ready <= 1'b0;
			if (mem_resp_valid && mem_resp_ready) begin
				mem_resp_valid <= 1'b0;
			end
			if (mem_req_valid && mem_req_ready) begin
				busy      <= 1'b1;
				resp_wait <= int'(random_bits(2));
				for (int k = 0; k < strb_width; k++) begin
					if (mem_req.write) begin
						if (mem_req.strb[k]) begin
							mem[base + k] <= mem_req.wdata[8*k +: 8];
						end
						mem_resp.rdata[8*k +: 8] <= 8'h00;
					end else begin
						mem_resp.rdata[8*k +: 8] <= mem[base + k];
					end
				end
			end else if (busy) begin
				if (resp_wait == 0) begin
					mem_resp_valid <= 1'b1;
					busy           <= 1'b0;
				end else begin
					resp_wait <= resp_wait - 1;
				end
			end else if (mem_req_valid && !mem_resp_valid) begin
				// stall a random number of cycles before taking the request
				if (ready_wait == 0) begin
					mem_req_ready <= 1'b1;
					ready_wait    <= int'(random_bits(2));
				end else begin
					ready_wait <= ready_wait - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* bench/lsu_bench.sv */
`default_nettype none

module lsu_bench
	import lsu_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_requests = 300;
	localparam int cycle_limit  = 40 * num_requests + 100;

	logic          clock;
	logic          reset;
	logic          req_valid;
	lsu_request_t  request;
	logic          req_ready;
	logic          mem_req_valid;
	bus_request_t  mem_req;
	logic          mem_req_ready;
	logic          mem_resp_valid;
	bus_response_t mem_resp;
	logic          mem_resp_ready;
	logic          result_valid;
	lsu_result_t   result;

	logic [15:0]  lfsr = 16'd37915;
	logic [7:0]   model_mem [512];
	lsu_result_t  expected_q [$];
	string        result_name_q [$];
	bus_request_t beat_q [$];
	string        beat_name_q [$];
	int           value_errors = 0;
	int           other_errors = 0;
	int           cycle_count = 0;

	clock_gen clock_gen_inst (
		.clock (clock),
		.reset (reset)
	);

	mem_responder mem_responder_inst (
		.clock          (clock),
		.reset          (reset),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_resp_ready (mem_resp_ready),
		.mem_req_ready  (mem_req_ready),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp       (mem_resp)
	);

	lsu_top lsu_top_inst (
		.clock          (clock),
		.reset          (reset),
		.req_valid      (req_valid),
		.request        (request),
		.mem_req_ready  (mem_req_ready),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp       (mem_resp),
		.req_ready      (req_ready),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_resp_ready (mem_resp_ready),
		.result_valid   (result_valid),
		.result         (result)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	task automatic check_result(input string name, input lsu_result_t expected,
		input lsu_result_t actual);
		if (actual !== expected) begin
			$write("Error %s: expected rd %0d data %h reg_write %b",
				name, expected.rd, expected.data, expected.reg_write);
			$display(", actual rd %0d data %h reg_write %b",
				actual.rd, actual.data, actual.reg_write);
			value_errors++;
		end
	endtask

	task automatic check_bus(input string name, input bus_request_t expected,
		input bus_request_t actual);
		if (actual !== expected) begin
			$write("Error %s: expected addr %h write %b strb %b wdata %h",
				name, expected.addr, expected.write, expected.strb, expected.wdata);
			$display(", actual addr %h write %b strb %b wdata %h",
				actual.addr, actual.write, actual.strb, actual.wdata);
			value_errors++;
		end
	endtask

	// --------------------------------------------------
	// reference model, applied in acceptance order
	// --------------------------------------------------
	task automatic predict_access(input int index, input lsu_request_t req);
		int           size;
		int           base;
		int           b;
		int           half;
		logic         is_store;
		word_t        value;
		bus_request_t beat [2];
		lsu_result_t  expected;
		string        name;
		name = $sformatf("access %0d %s @%h", index, req.op.name(), req.addr);
		is_store = req.op inside {op_sb, op_sh, op_sw};
		size = (req.op inside {op_lw, op_sw}) ? 4
			: (req.op inside {op_lh, op_lhu, op_sh}) ? 2 : 1;
		base = int'(req.addr) & ~3;
		value = '0;
		for (int j = 0; j < 2; j++) begin
			beat[j] = '0;
			beat[j].addr = addr_t'(base + 4 * j);
			beat[j].write = is_store;
		end
		for (int i = 0; i < size; i++) begin
			b = int'(req.addr) + i;
			half = (b >= base + 4) ? 1 : 0;
			// lane is the byte address within the 8-byte bus word
			beat[half].strb[b % 8] = 1'b1;
			if (is_store) begin
				beat[half].wdata[8*(b % 8) +: 8] = req.store_data[8*i +: 8];
				model_mem[b] = req.store_data[8*i +: 8];
			end else begin
				value[8*i +: 8] = model_mem[b];
			end
		end
		case (req.op)
			op_lb:   value = {{24{value[7]}}, value[7:0]};
			op_lh:   value = {{16{value[15]}}, value[15:0]};
			default: value = value;
		endcase
		expected.rd = req.rd;
		expected.data = value;
		expected.reg_write = !is_store;
		expected_q.push_back(expected);
		result_name_q.push_back(name);
		beat_q.push_back(beat[0]);
		beat_name_q.push_back({name, " beat 0"});
		if (int'(req.addr) + size - 1 >= base + 4) begin
			beat_q.push_back(beat[1]);
			beat_name_q.push_back({name, " beat 1"});
		end
	endtask

	// --------------------------------------------------
	// monitors, sampled mid-cycle
	// --------------------------------------------------
	always @(negedge clock) begin
		bus_request_t seen;
		if (!reset && mem_req_valid && mem_req_ready) begin
			seen = mem_req;
			// only strobed write lanes carry meaning
			for (int k = 0; k < strb_width; k++) begin
				if (!seen.write || !seen.strb[k]) begin
					seen.wdata[8*k +: 8] = 8'h00;
				end
			end
			if (beat_q.size() == 0) begin
				$display("bus request at %h with no access expecting one", seen.addr);
				other_errors++;
			end else begin
				check_bus(beat_name_q.pop_front(), beat_q.pop_front(), seen);
			end
		end
	end

	always @(negedge clock) begin
		if (!reset && result_valid) begin
			if (expected_q.size() == 0) begin
				$display("result for rd %0d arrived with no access outstanding", result.rd);
				other_errors++;
			end else begin
				check_result(result_name_q.pop_front(), expected_q.pop_front(), result);
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d results still outstanding",
				cycle_count, expected_q.size());
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		lsu_request_t req;
		int           gap;
		logic         taken;
		req_valid = 1'b0;
		request = '0;
		for (int i = 0; i < 512; i++) begin
			model_mem[i] = 8'(i * 13) ^ 8'(i >> 8);
		end
		@(negedge reset);
		@(negedge clock);
		if (req_ready !== 1'b1 || mem_req_valid !== 1'b0 || mem_resp_ready !== 1'b0
			|| result_valid !== 1'b0) begin
			$write("outputs wrong after reset: req_ready %b mem_req_valid %b",
				req_ready, mem_req_valid);
			$display(" mem_resp_ready %b result_valid %b", mem_resp_ready, result_valid);
			other_errors++;
		end
		@(posedge clock);
		#1;
		for (int n = 0; n < num_requests; n++) begin
			req.op = lsu_op_t'(random_bits(3));
			req.addr = addr_t'(random_bits(8));
			req.store_data = random_bits(32);
			req.rd = reg_addr_t'(random_bits(5));
			gap = int'(random_bits(2));
			req_valid = 1'b1;
			request = req;
			taken = 1'b0;
			while (!taken) begin
				@(negedge clock);
				taken = req_ready;
				if (taken) begin
					predict_access(n, req);
				end
				@(posedge clock);
				#1;
			end
			req_valid = 1'b0;
			// a zero gap keeps requests back to back
			repeat (gap) begin
				@(posedge clock);
				#1;
			end
		end
		while (expected_q.size() != 0) begin
			@(negedge clock);
		end
		repeat (8) @(negedge clock);
		if (beat_q.size() != 0) begin
			$display("%0d expected bus requests never appeared", beat_q.size());
			other_errors++;
		end
		$display("%0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* lsu_top.f */
logic/lsu_pkg.sv
logic/access_planner.sv
logic/bus_sequencer.sv
logic/load_aligner.sv
logic/lsu_top.sv
bench/clock_gen.sv
bench/mem_responder.sv
bench/lsu_bench.sv

/* Makefile */
SOURCES := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vlsu_bench

obj_dir/Vlsu_bench: lsu_top.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module lsu_bench -f lsu_top.f

run: obj_dir/Vlsu_bench
	./obj_dir/Vlsu_bench | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
